// ==== design/io_pkg.sv ====
package io_pkg;

  localparam int DATA_W = 32;
  localparam int ADR_W  = 16;

  // unit field is adr[15:12]
  localparam logic [3:0] UNIT_SEGFAN = 4'h0;
  localparam logic [3:0] UNIT_SWLED  = 4'h1;
  localparam logic [3:0] UNIT_TIMER  = 4'h8;

  typedef enum logic [2:0] {
    S_IDLE,
    S_DONE,
    S_SEGFAN,
    S_SWLED,
    S_TIMER
  } io_state_t;

  localparam logic [DATA_W-1:0] SEG_RESET = 32'h0;
  localparam logic [DATA_W-1:0] FAN_RESET = 32'h80;

  localparam int FAN_W    = 8;
  localparam int N_TIMERS = 4;
  localparam int LED_W    = 9;
  localparam int SW_W     = 16;

  // timer word indices
  localparam logic [3:0] TMR_RELOAD0 = 4'd0;
  localparam logic [3:0] TMR_RELOAD1 = 4'd1;
  localparam logic [3:0] TMR_RELOAD2 = 4'd2;
  localparam logic [3:0] TMR_RELOAD3 = 4'd3;
  localparam logic [3:0] TMR_CTRL    = 4'd4;
  localparam logic [3:0] TMR_STATUS  = 4'd5;  // read flags, write 1 to clear
  localparam logic [3:0] TMR_COUNT0  = 4'd6;
  localparam logic [3:0] TMR_COUNT1  = 4'd7;
  localparam logic [3:0] TMR_COUNT2  = 4'd8;
  localparam logic [3:0] TMR_COUNT3  = 4'd9;

  // replace the bytes of old_v selected by sel
  function automatic logic [DATA_W-1:0] byte_merge(input logic [DATA_W-1:0] old_v,
                                                   input logic [DATA_W-1:0] new_v,
                                                   input logic [3:0]        sel);
    logic [DATA_W-1:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (sel[b])
        res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

endpackage

// ==== design/fan_pwm.sv ====
module fan_pwm
  import io_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [FAN_W-1:0] speed_i,
  output logic             fan_o
);

  logic [FAN_W-1:0] cnt_q;
  logic             fan_q;

  assign fan_o = fan_q;

  // 256-cycle period, high for speed_i cycles
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      fan_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
      fan_q <= (cnt_q < speed_i);  // registered so the pin never glitches
    end
  end

endmodule

// ==== design/seg_digits.sv ====
module seg_digits
  import io_pkg::*;
(
  input  logic [DATA_W-1:0] value_i,
  output logic [6:0]        hex0_o,
  output logic [6:0]        hex1_o,
  output logic [6:0]        hex2_o,
  output logic [6:0]        hex3_o,
  output logic [6:0]        hex4_o,
  output logic [6:0]        hex5_o,
  output logic [6:0]        hex6_o,
  output logic [6:0]        hex7_o
);

  logic [6:0] seg [DATA_W/4];

  // active low, bit 0 is segment a
  function automatic logic [6:0] hex_pattern(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'ha: return 7'h08;
      4'hb: return 7'h03;
      4'hc: return 7'h46;
      4'hd: return 7'h21;
      4'he: return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  for (genvar d = 0; d < DATA_W/4; d++) begin : g_digit
    assign seg[d] = hex_pattern(value_i[4*d +: 4]);
  end

  assign hex0_o = seg[0];
  assign hex1_o = seg[1];
  assign hex2_o = seg[2];
  assign hex3_o = seg[3];
  assign hex4_o = seg[4];
  assign hex5_o = seg[5];
  assign hex6_o = seg[6];
  assign hex7_o = seg[7];

endmodule

// ==== design/timer_int.sv ====
module timer_int
  import io_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [3:0]          sel_i,
  input  logic [3:0]          widx_i,
  input  logic [DATA_W-1:0]   dat_i,
  output logic                ack_o,
  output logic [DATA_W-1:0]   dat_o,
  output logic [N_TIMERS-1:0] irq_o
);

  logic [DATA_W-1:0]   reload_q [N_TIMERS];
  logic [DATA_W-1:0]   count_q  [N_TIMERS];
  logic [N_TIMERS-1:0] enable_q;
  logic [N_TIMERS-1:0] flag_q;
  logic [N_TIMERS-1:0] reload_wr;
  logic [N_TIMERS-1:0] start;
  logic [N_TIMERS-1:0] fire;
  logic [N_TIMERS-1:0] clr;
  logic [DATA_W-1:0]   rd_data;
  logic                access;
  logic                wr_ctrl;

  assign access  = stb_i & ~ack_o;  // one access per strobe
  assign wr_ctrl = access & we_i & (widx_i == TMR_CTRL);
  assign clr     = (access && we_i && widx_i == TMR_STATUS) ? dat_i[N_TIMERS-1:0] : '0;
  assign irq_o   = flag_q;

  always_comb begin
    rd_data   = '0;
    reload_wr = '0;
    case (widx_i)
      TMR_RELOAD0: begin
        rd_data      = reload_q[0];
        reload_wr[0] = access & we_i;
      end
      TMR_RELOAD1: begin
        rd_data      = reload_q[1];
        reload_wr[1] = access & we_i;
      end
      TMR_RELOAD2: begin
        rd_data      = reload_q[2];
        reload_wr[2] = access & we_i;
      end
      TMR_RELOAD3: begin
        rd_data      = reload_q[3];
        reload_wr[3] = access & we_i;
      end
      TMR_CTRL:   rd_data = {{(DATA_W-N_TIMERS){1'b0}}, enable_q};
      TMR_STATUS: rd_data = {{(DATA_W-N_TIMERS){1'b0}}, flag_q};
      TMR_COUNT0: rd_data = count_q[0];
      TMR_COUNT1: rd_data = count_q[1];
      TMR_COUNT2: rd_data = count_q[2];
      TMR_COUNT3: rd_data = count_q[3];
      default:    rd_data = '0;
    endcase
  end

  always_comb begin
    for (int i = 0; i < N_TIMERS; i++) begin
      start[i] = wr_ctrl & dat_i[i] & ~enable_q[i];  // rising enable loads the counter
      fire[i]  = enable_q[i] & (count_q[i] == '0);
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ack_o    <= 1'b0;
      enable_q <= '0;
      flag_q   <= '0;
      for (int i = 0; i < N_TIMERS; i++)
        count_q[i] <= '0;
    end else begin
      ack_o  <= access;
      flag_q <= (flag_q & ~clr) | fire;  // set wins over clear
      if (wr_ctrl)
        enable_q <= dat_i[N_TIMERS-1:0];
      for (int i = 0; i < N_TIMERS; i++) begin
        if (start[i] || fire[i])
          count_q[i] <= reload_q[i];
        else if (enable_q[i])
          count_q[i] <= count_q[i] - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access)
      dat_o <= rd_data;
    for (int i = 0; i < N_TIMERS; i++) begin
      if (reload_wr[i])
        reload_q[i] <= byte_merge(reload_q[i], dat_i, sel_i);
    end
  end

endmodule

// ==== design/io_bus_fsm.sv ====
module io_bus_fsm
  import io_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [3:0]        sel_i,
  input  logic [ADR_W-1:0]  adr_i,
  input  logic [DATA_W-1:0] dat_i,
  input  logic [SW_W-1:0]   sw_i,
  input  logic              tmr_ack_i,
  input  logic [DATA_W-1:0] tmr_dat_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] dat_o,
  output logic [LED_W-1:0]  led_o,
  output logic [DATA_W-1:0] seg_value_o,
  output logic [DATA_W-1:0] fan_speed_o,
  output logic              tmr_stb_o
);

  io_state_t         state_q, state_next;
  logic [DATA_W-1:0] seg_q, seg_next;
  logic [DATA_W-1:0] fan_q, fan_next;
  logic [LED_W-1:0]  led_q, led_next;
  logic [DATA_W-1:0] result_q, result_next;
  logic [3:0]        unit;
  logic [DATA_W-1:0] led_word;  // led register after a byte-enabled write

  assign unit     = adr_i[ADR_W-1 -: 4];
  assign led_word = byte_merge({{(DATA_W-LED_W){1'b0}}, led_q}, dat_i, sel_i);

  assign ack_o       = (state_q == S_DONE);
  assign dat_o       = result_q;
  assign led_o       = led_q;
  assign seg_value_o = seg_q;
  assign fan_speed_o = fan_q;
  assign tmr_stb_o   = (state_q == S_TIMER);  // held until timer acks

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q  <= S_IDLE;
      seg_q    <= SEG_RESET;
      fan_q    <= FAN_RESET;
      led_q    <= '0;
      result_q <= '0;
    end else begin
      state_q  <= state_next;
      seg_q    <= seg_next;
      fan_q    <= fan_next;
      led_q    <= led_next;
      result_q <= result_next;
    end
  end

  always_comb begin
    state_next  = state_q;
    seg_next    = seg_q;
    fan_next    = fan_q;
    led_next    = led_q;
    result_next = result_q;
    case (state_q)
      S_IDLE: begin
        if (cyc_i && stb_i) begin
          case (unit)
            UNIT_SEGFAN: state_next = S_SEGFAN;
            UNIT_SWLED:  state_next = S_SWLED;
            UNIT_TIMER:  state_next = S_TIMER;
            default: begin
              // nothing behind this unit, answer with zero
              result_next = '0;
              state_next  = S_DONE;
            end
          endcase
        end
      end
      S_SEGFAN: begin
        if (we_i) begin
          if (adr_i[2])
            fan_next = byte_merge(fan_q, dat_i, sel_i);
          else
            seg_next = byte_merge(seg_q, dat_i, sel_i);
        end else begin
          result_next = adr_i[2] ? fan_q : seg_q;
        end
        state_next = S_DONE;
      end
      S_SWLED: begin
        if (we_i)
          led_next = led_word[LED_W-1:0];  // either word writes the leds
        else if (adr_i[2])
          result_next = {{(DATA_W-LED_W){1'b0}}, led_q};
        else
          result_next = {{(DATA_W-SW_W){1'b0}}, sw_i};
        state_next = S_DONE;
      end
      S_TIMER: begin
        if (tmr_ack_i) begin
          if (!we_i)
            result_next = tmr_dat_i;
          state_next = S_DONE;
        end
      end
      S_DONE: state_next = S_IDLE;
      default: state_next = S_IDLE;
    endcase
  end

endmodule

// ==== design/io_subsys.sv ====
module io_subsys
  import io_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [3:0]          sel_i,
  input  logic [ADR_W-1:0]    adr_i,
  input  logic [DATA_W-1:0]   dat_i,
  output logic [DATA_W-1:0]   dat_o,
  output logic                ack_o,
  input  logic [SW_W-1:0]     sw_i,
  output logic [LED_W-1:0]    led_o,
  output logic                fan_o,
  output logic [6:0]          hex0_o,
  output logic [6:0]          hex1_o,
  output logic [6:0]          hex2_o,
  output logic [6:0]          hex3_o,
  output logic [6:0]          hex4_o,
  output logic [6:0]          hex5_o,
  output logic [6:0]          hex6_o,
  output logic [6:0]          hex7_o,
  output logic [N_TIMERS-1:0] interrupts_o
);

  logic [DATA_W-1:0] seg_value;
  logic [DATA_W-1:0] fan_speed;
  logic              tmr_stb;
  logic              tmr_ack;
  logic [DATA_W-1:0] tmr_dat;

  io_bus_fsm i_io_bus_fsm (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .sel_i       (sel_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .sw_i        (sw_i),
    .tmr_ack_i   (tmr_ack),
    .tmr_dat_i   (tmr_dat),
    .ack_o       (ack_o),
    .dat_o       (dat_o),
    .led_o       (led_o),
    .seg_value_o (seg_value),
    .fan_speed_o (fan_speed),
    .tmr_stb_o   (tmr_stb)
  );

  timer_int i_timer_int (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .stb_i  (tmr_stb),
    .we_i   (we_i),
    .sel_i  (sel_i),
    .widx_i (adr_i[5:2]),  // word index inside the timer unit
    .dat_i  (dat_i),
    .ack_o  (tmr_ack),
    .dat_o  (tmr_dat),
    .irq_o  (interrupts_o)
  );

  fan_pwm i_fan_pwm (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .speed_i (fan_speed[FAN_W-1:0]),
    .fan_o   (fan_o)
  );

  seg_digits i_seg_digits (
    .value_i (seg_value),
    .hex0_o  (hex0_o),
    .hex1_o  (hex1_o),
    .hex2_o  (hex2_o),
    .hex3_o  (hex3_o),
    .hex4_o  (hex4_o),
    .hex5_o  (hex5_o),
    .hex6_o  (hex6_o),
    .hex7_o  (hex7_o)
  );

endmodule

// ==== verif/io_model.svh ====
`ifndef IO_MODEL_SVH
`define IO_MODEL_SVH

localparam int ACK_LIMIT = 10;  // cycles per bus access

logic [DATA_W-1:0]   shadow_seg;
logic [DATA_W-1:0]   shadow_fan;
logic [LED_W-1:0]    shadow_led;
logic [DATA_W-1:0]   shadow_reload [N_TIMERS];
logic [N_TIMERS-1:0] shadow_enable;
logic [N_TIMERS-1:0] shadow_flags;

task automatic model_reset();
  shadow_seg    = 32'h0;
  shadow_fan    = 32'h80;
  shadow_led    = '0;
  shadow_enable = '0;
  shadow_flags  = '0;
  for (int i = 0; i < N_TIMERS; i++)
    shadow_reload[i] = 'x;  // undefined until written
endtask

function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_v,
                                                  input logic [DATA_W-1:0] new_v,
                                                  input logic [3:0]        sel);
  logic [DATA_W-1:0] mask;
  mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  return (old_v & ~mask) | (new_v & mask);
endfunction

// lit segments gfedcba, inverted for the active-low pins
function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
  logic [6:0] lit;
  case (nib)
    4'h0: lit = 7'h3f;
    4'h1: lit = 7'h06;
    4'h2: lit = 7'h5b;
    4'h3: lit = 7'h4f;
    4'h4: lit = 7'h66;
    4'h5: lit = 7'h6d;
    4'h6: lit = 7'h7d;
    4'h7: lit = 7'h07;
    4'h8: lit = 7'h7f;
    4'h9: lit = 7'h6f;
    4'ha: lit = 7'h77;
    4'hb: lit = 7'h7c;
    4'hc: lit = 7'h39;
    4'hd: lit = 7'h5e;
    4'he: lit = 7'h79;
    default: lit = 7'h71;
  endcase
  return ~lit;
endfunction

function automatic logic [55:0] expected_hex(input logic [DATA_W-1:0] v);
  logic [55:0] res;
  for (int d = 0; d < 8; d++)
    res[7*d +: 7] = seg_pattern(v[4*d +: 4]);
  return res;
endfunction

function automatic void model_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                                    input logic [3:0] sel);
  logic [DATA_W-1:0] led_word;
  led_word = merge_bytes({{(DATA_W-LED_W){1'b0}}, shadow_led}, dat, sel);
  case (adr[15:12])
    4'h0: begin
      if (adr[2])
        shadow_fan = merge_bytes(shadow_fan, dat, sel);
      else
        shadow_seg = merge_bytes(shadow_seg, dat, sel);
    end
    4'h1: shadow_led = led_word[LED_W-1:0];  // both words hit the leds
    4'h8: begin
      if (adr[5:2] < 4)
        shadow_reload[adr[3:2]] = merge_bytes(shadow_reload[adr[3:2]], dat, sel);
      else if (adr[5:2] == 4)
        shadow_enable = dat[N_TIMERS-1:0];
      else if (adr[5:2] == 5)
        shadow_flags = shadow_flags & ~dat[N_TIMERS-1:0];
    end
    default: ;
  endcase
endfunction

function automatic logic [DATA_W-1:0] model_read(input logic [ADR_W-1:0] adr);
  case (adr[15:12])
    4'h0: return adr[2] ? shadow_fan : shadow_seg;
    4'h1: return adr[2] ? {{(DATA_W-LED_W){1'b0}}, shadow_led} : {{(DATA_W-SW_W){1'b0}}, sw_i};
    4'h8: begin
      if (adr[5:2] < 4)
        return shadow_reload[adr[3:2]];
      else if (adr[5:2] == 4)
        return {{(DATA_W-N_TIMERS){1'b0}}, shadow_enable};
      else if (adr[5:2] == 5)
        return {{(DATA_W-N_TIMERS){1'b0}}, shadow_flags};
      return '0;
    end
    default: return '0;
  endcase
endfunction

// unit in bits 15:12, word index in bits 5:2, the rest random
function automatic logic [ADR_W-1:0] make_adr(input logic [3:0] unit, input logic [3:0] widx);
  logic [31:0] r;
  r = $urandom;
  return {unit, r[5:0], widx, r[7:6]};
endfunction

task automatic bus_access(input logic we, input logic [3:0] sel, input logic [ADR_W-1:0] adr,
                          input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
  int waited;
  waited = 0;
  @(posedge clk_i);
  cyc_i <= 1'b1;
  stb_i <= 1'b1;
  we_i  <= we;
  sel_i <= sel;
  adr_i <= adr;
  dat_i <= wdat;
  @(negedge clk_i);
  while (!ack_o) begin
    waited++;
    if (waited > ACK_LIMIT) begin
      $display("no ack from bus for address 0x%h", adr);
      stop_with_failure();
    end
    @(negedge clk_i);
  end
  rdat = dat_o;
  @(posedge clk_i);
  cyc_i <= 1'b0;
  stb_i <= 1'b0;
  we_i  <= 1'b0;
endtask

task automatic bus_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                         input logic [3:0] sel);
  logic [DATA_W-1:0] unused;
  bus_access(1'b1, sel, adr, dat, unused);
  model_write(adr, dat, sel);
endtask

`endif

// ==== verif/io_subsys_tb.sv ====
module io_subsys_tb
  import io_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;  // run needs roughly 8k

  logic                clk_i;
  logic                rst_i;
  logic                cyc_i;
  logic                stb_i;
  logic                we_i;
  logic [3:0]          sel_i;
  logic [ADR_W-1:0]    adr_i;
  logic [DATA_W-1:0]   dat_i;
  logic [DATA_W-1:0]   dat_o;
  logic                ack_o;
  logic [SW_W-1:0]     sw_i;
  logic [LED_W-1:0]    led_o;
  logic                fan_o;
  logic [6:0]          hex0_o;
  logic [6:0]          hex1_o;
  logic [6:0]          hex2_o;
  logic [6:0]          hex3_o;
  logic [6:0]          hex4_o;
  logic [6:0]          hex5_o;
  logic [6:0]          hex6_o;
  logic [6:0]          hex7_o;
  logic [N_TIMERS-1:0] interrupts_o;
  int unsigned         cycle_cnt = 0;

  `include "io_model.svh"

  io_subsys i_io_subsys (
    .clk_i (clk_i), .rst_i (rst_i), .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i),
    .sel_i (sel_i), .adr_i (adr_i), .dat_i (dat_i), .dat_o (dat_o), .ack_o (ack_o),
    .sw_i (sw_i), .led_o (led_o), .fan_o (fan_o),
    .hex0_o (hex0_o), .hex1_o (hex1_o), .hex2_o (hex2_o), .hex3_o (hex3_o),
    .hex4_o (hex4_o), .hex5_o (hex5_o), .hex6_o (hex6_o), .hex7_o (hex7_o),
    .interrupts_o (interrupts_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic read_and_check(input logic [ADR_W-1:0] adr);
    logic [DATA_W-1:0] rd;
    bus_access(1'b0, 4'h0, adr, $urandom, rd);
    check_value("dat_o", rd, model_read(adr));
  endtask

  task automatic check_outputs();
    @(negedge clk_i);
    check_value("led_o", led_o, shadow_led);
    check_value("interrupts_o", interrupts_o, shadow_flags);
    check_value("hex7_o..hex0_o", {hex7_o, hex6_o, hex5_o, hex4_o, hex3_o, hex2_o, hex1_o,
                hex0_o}, expected_hex(shadow_seg));
  endtask

  task automatic check_all_regs();
    read_and_check(make_adr(UNIT_SEGFAN, 4'h0));
    read_and_check(make_adr(UNIT_SEGFAN, 4'h1));
    read_and_check(make_adr(UNIT_SWLED, 4'h1));
    for (int w = 0; w < 6; w++)
      read_and_check(make_adr(UNIT_TIMER, 4'(w)));  // reloads, ctrl, status
    check_outputs();
  endtask

  task automatic after_reset_test();
    logic [DATA_W-1:0] rd;
    read_and_check(make_adr(UNIT_SEGFAN, 4'h0));
    read_and_check(make_adr(UNIT_SEGFAN, 4'h1));
    read_and_check(make_adr(UNIT_TIMER, 4'd4));
    for (int w = 6; w < 10; w++) begin
      bus_access(1'b0, 4'h0, make_adr(UNIT_TIMER, 4'(w)), '0, rd);
      check_value("dat_o", rd, 0);  // counters idle
    end
    check_outputs();
  endtask

  task automatic local_test();
    logic [ADR_W-1:0] adr;
    repeat (200) begin
      adr = make_adr(4'($urandom_range(1, 0)), 4'($urandom));
      if ($urandom_range(1, 0))
        bus_write(adr, $urandom, 4'($urandom));
      else
        read_and_check(adr);
      check_outputs();
    end
  endtask

  task automatic switch_test();
    repeat (20) begin
      @(posedge clk_i);
      sw_i <= SW_W'($urandom);
      read_and_check(make_adr(UNIT_SWLED, 4'h0));
    end
  endtask

  task automatic fan_test();
    logic [DATA_W-1:0] word;
    int                high;
    repeat (20) begin
      word = $urandom;
      bus_write(make_adr(UNIT_SEGFAN, 4'h1), word, 4'hf);
      high = 0;
      repeat (256) begin
        @(negedge clk_i);
        if (fan_o)
          high++;
      end
      check_value("fan_o high cycles", high, word[FAN_W-1:0]);
    end
  endtask

  task automatic timer_test();
    int ch;
    int reload;
    int waited;
    repeat (6) begin
      ch     = $urandom_range(N_TIMERS-1, 0);
      reload = $urandom_range(40, 8);
      bus_write(make_adr(UNIT_TIMER, 4'(ch)), reload, 4'hf);
      bus_write(make_adr(UNIT_TIMER, 4'd4), 32'h1 << ch, 4'hf);
      waited = 0;
      @(negedge clk_i);
      while (!interrupts_o[ch]) begin
        waited++;
        if (waited > reload + 3) begin
          $display("timer channel %0d raised no interrupt within %0d cycles", ch, reload + 3);
          stop_with_failure();
        end
        @(negedge clk_i);
      end
      shadow_flags[ch] = 1'b1;  // sticky until cleared
      read_and_check(make_adr(UNIT_TIMER, 4'd4));
      read_and_check(make_adr(UNIT_TIMER, 4'd5));
      bus_write(make_adr(UNIT_TIMER, 4'd4), 32'h0, 4'hf);
      bus_write(make_adr(UNIT_TIMER, 4'd5), 32'h1 << ch, 4'hf);
      check_outputs();
    end
    for (int i = 0; i < N_TIMERS; i++)
      bus_write(make_adr(UNIT_TIMER, 4'(i)), $urandom, 4'hf);
    repeat (12)
      bus_write(make_adr(UNIT_TIMER, 4'($urandom_range(3, 0))), $urandom, 4'($urandom));
    for (int i = 0; i < N_TIMERS; i++)
      read_and_check(make_adr(UNIT_TIMER, 4'(i)));
  endtask

  task automatic unmapped_test();
    logic [3:0]       unit;
    logic [ADR_W-1:0] adr;
    repeat (30) begin
      unit = 4'($urandom);
      while (unit == UNIT_SEGFAN || unit == UNIT_SWLED || unit == UNIT_TIMER)
        unit = 4'($urandom);
      adr = make_adr(unit, 4'($urandom));
      if ($urandom_range(1, 0)) begin
        bus_write(adr, $urandom, 4'($urandom));
        check_all_regs();
      end else begin
        read_and_check(adr);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h7596_69b0));
    model_reset();
    rst_i <= 1'b1;
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
    sel_i <= 4'h0;
    adr_i <= '0;
    dat_i <= '0;
    sw_i  <= '0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    after_reset_test();
    local_test();
    switch_test();
    fan_test();
    timer_test();
    unmapped_test();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== io_subsys.f ====
+incdir+verif
design/io_pkg.sv
design/fan_pwm.sv
design/seg_digits.sv
design/timer_int.sv
design/io_bus_fsm.sv
design/io_subsys.sv
verif/io_subsys_tb.sv
